// File: files.f
+incdir+src
src/mem_bus_pkg.sv
src/irq_pkg.sv
src/dp_ram.sv
src/data_decoder.sv
src/exit_ctrl.sv
src/timer_irq.sv
src/mm_ram_top.sv
sim/tb_mm_ram.sv

// File: sim/tb_mm_ram.sv
// directed testbench of the memory subsystem that acts as the core
// drivers for the instruction and data ports, interrupt acknowledge
// RAM model, value checks, watchdog and the closing summary

`include "mm_defines.svh"

module tb_mm_ram
    import mem_bus_pkg::*;
    import irq_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD     = 4;
    localparam int RESET_CYCLES   = 10;
    localparam int RAM_WORDS      = 16;
    localparam int PARTIAL_WRITES = 32;
    localparam int TIMER_LOAD     = 10;
    localparam int TEST_CYCLES    = RESET_CYCLES
                                  + 2 * (3 * RAM_WORDS + PARTIAL_WRITES + 30)
                                  + TIMER_LOAD + 30;
    localparam int MARGIN_NS      = 200;

    logic        clk;
    logic        arst_n;
    instr_req_t  instr_req;
    instr_rsp_t  instr_rsp;
    data_req_t   data_req;
    data_rsp_t   data_rsp;
    irq_id_t     irq_id;
    logic        irq_ack;
    irq_lines_t  irq;
    logic        tests_passed;
    logic        tests_failed;
    logic        exit_valid;
    word_t       exit_value;

    int          errors = 0;
    int          checks = 0;
    int unsigned cycle = 0;
    word_t       lcg_state = 32'd92810;
    addr_t       ram_addrs[$];
    word_t       ram_model[int];

    mm_ram_top UUT (
        .clk_i          ( clk          ),
        .arst_n_i       ( arst_n       ),
        .instr_req_i    ( instr_req    ),
        .instr_rsp_o    ( instr_rsp    ),
        .data_req_i     ( data_req     ),
        .data_rsp_o     ( data_rsp     ),
        .irq_id_i       ( irq_id       ),
        .irq_ack_i      ( irq_ack      ),
        .irq_o          ( irq          ),
        .tests_passed_o ( tests_passed ),
        .tests_failed_o ( tests_failed ),
        .exit_valid_o   ( exit_valid   ),
        .exit_value_o   ( exit_value   )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // counts rising edges and is read only on falling edges
    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // expected word after a write with byte enables
    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w, input be_t be);
        word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic check(input string msg, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s, got %h, expected %h", $time, msg, got, exp);
            errors++;
        end
    endtask

    // drives one data request and returns at the falling edge where rvalid is seen
    task automatic data_access(input logic we, input addr_t addr, input be_t be,
                               input word_t wdata, output word_t rdata);
        int waited;
        @(negedge clk);
        data_req.req   = 1'b1;
        data_req.addr  = addr;
        data_req.we    = we;
        data_req.be    = be;
        data_req.wdata = wdata;
        @(posedge clk);
        if (!data_rsp.gnt) begin
            $display("ERROR at %0t: data request to %h was not granted", $time, addr);
            errors++;
        end
        @(negedge clk);
        data_req.req = 1'b0;
        waited = 1;
        while (!data_rsp.rvalid && waited < 4) begin
            @(negedge clk);
            waited++;
        end
        rdata = data_rsp.rdata;
        if (!data_rsp.rvalid) begin
            $display("ERROR at %0t: no rvalid for the data request to %h", $time, addr);
            errors++;
        end else begin
            check("data rvalid latency", waited, 1);
        end
    endtask

    task automatic data_write(input addr_t addr, input be_t be, input word_t wdata);
        word_t rdata;
        data_access(1'b1, addr, be, wdata, rdata);
        check("write response data", rdata, '0);
    endtask

    task automatic data_read(input addr_t addr, output word_t rdata);
        data_access(1'b0, addr, 4'hf, '0, rdata);
    endtask

    task automatic instr_read(input addr_t addr, output word_t rdata);
        int waited;
        @(negedge clk);
        instr_req.req  = 1'b1;
        instr_req.addr = addr;
        @(posedge clk);
        if (!instr_rsp.gnt) begin
            $display("ERROR at %0t: instruction fetch of %h was not granted", $time, addr);
            errors++;
        end
        @(negedge clk);
        instr_req.req = 1'b0;
        waited = 1;
        while (!instr_rsp.rvalid && waited < 4) begin
            @(negedge clk);
            waited++;
        end
        rdata = instr_rsp.rdata;
        if (!instr_rsp.rvalid) begin
            $display("ERROR at %0t: no rvalid for the instruction fetch of %h", $time, addr);
            errors++;
        end else begin
            check("instruction rvalid latency", waited, 1);
        end
    endtask

    // acknowledge is high for one edge
    task automatic ack_irq(input irq_id_t id);
        @(negedge clk);
        irq_id  = id;
        irq_ack = 1'b1;
        @(negedge clk);
        irq_ack = 1'b0;
        irq_id  = '0;
    endtask

    task automatic test_ram_data();
        addr_t addr;
        word_t wdata;
        word_t rdata;
        be_t   be;
        int    k;
        for (int i = 0; i < RAM_WORDS; i++) begin
            addr  = lcg_next() & 32'h0000_fffc;
            wdata = lcg_next();
            ram_addrs.push_back(addr);
            data_write(addr, 4'hf, wdata);
            ram_model[addr[15:2]] = wdata;
        end
        for (int i = 0; i < PARTIAL_WRITES; i++) begin
            k     = lcg_next() % RAM_WORDS;
            addr  = ram_addrs[k];
            be    = be_t'(lcg_next() >> 28);
            wdata = lcg_next();
            data_write(addr, be, wdata);
            ram_model[addr[15:2]] = merge_bytes(ram_model[addr[15:2]], wdata, be);
        end
        foreach (ram_addrs[i]) begin
            data_read(ram_addrs[i], rdata);
            check("RAM data read", rdata, ram_model[ram_addrs[i][15:2]]);
        end
    endtask

    task automatic test_instr_port();
        word_t rdata;
        foreach (ram_addrs[i]) begin
            instr_read(ram_addrs[i], rdata);
            check("instruction read", rdata, ram_model[ram_addrs[i][15:2]]);
        end
    endtask

    task automatic test_decoder();
        word_t rdata;
        word_t wdata;
        wdata = lcg_next();
        data_write(32'h0000_0000, 4'hf, wdata);
        ram_model[0] = wdata;
        data_read(32'h3000_0000, rdata);
        check("unmapped read", rdata, '0);
        // the address just above the RAM window would alias word 0 if the decoder wrapped
        data_write(32'h0001_0000, 4'hf, ~wdata);
        data_write(32'h2000_0008, 4'hf, `MM_PASS_MAGIC);
        data_read(32'h0000_0000, rdata);
        check("RAM word after unmapped write", rdata, ram_model[0]);
        check("passed after unmapped write", tests_passed, 1'b0);
        check("failed after unmapped write", tests_failed, 1'b0);
        check("exit valid after unmapped write", exit_valid, 1'b0);
        check("exit value after unmapped write", exit_value, '0);
        check("irq lines after unmapped write", irq, '0);
    endtask

    task automatic test_exit_status();
        word_t value;
        data_write(`MM_TEST_STATUS_ADDR, 4'hf, 32'h0000_1234);
        check("passed after other status", tests_passed, 1'b0);
        check("failed after other status", tests_failed, 1'b0);
        data_write(`MM_TEST_STATUS_ADDR, 4'hf, `MM_FAIL_MAGIC);
        check("failed after fail magic", tests_failed, 1'b1);
        check("passed after fail magic", tests_passed, 1'b0);
        data_write(`MM_TEST_STATUS_ADDR, 4'hf, `MM_PASS_MAGIC);
        check("passed after pass magic", tests_passed, 1'b1);
        value = lcg_next();
        data_write(`MM_EXIT_ADDR, 4'hf, value);
        check("exit valid", exit_valid, 1'b1);
        check("exit value", exit_value, value);
    endtask

    task automatic test_timer();
        int unsigned load_cycle;
        word_t       rdata;
        data_write(`MM_TIMER_CNT_ADDR, 4'hf, TIMER_LOAD);
        load_cycle = cycle;
        data_read(`MM_TIMER_CNT_ADDR, rdata);
        check("timer count", rdata, TIMER_LOAD - (cycle - load_cycle));
        while ((cycle - load_cycle) < TIMER_LOAD + 2) begin
            check("timer line", irq.timer, (cycle - load_cycle) >= TIMER_LOAD);
            @(negedge clk);
        end
        ack_irq(IRQ_ID_SOFTWARE);
        check("timer line after software ack", irq.timer, 1'b1);
        ack_irq(IRQ_ID_TIMER);
        check("timer line after timer ack", irq.timer, 1'b0);
        // zero leaves the timer disarmed, so the count must not start running
        data_write(`MM_TIMER_CNT_ADDR, 4'hf, 32'd0);
        repeat (4) @(negedge clk);
        check("timer line after zero load", irq.timer, 1'b0);
        data_read(`MM_TIMER_CNT_ADDR, rdata);
        check("timer count after zero load", rdata, 32'd0);
    endtask

    task automatic test_sw_irq();
        data_write(`MM_SW_IRQ_ADDR, 4'hf, 32'd1);
        check("software line after write", irq.software, 1'b1);
        ack_irq(IRQ_ID_SOFTWARE);
        check("software line after ack", irq.software, 1'b0);
    endtask

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        instr_req = '0;
        data_req  = '0;
        irq_id    = '0;
        irq_ack   = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;
        check("instruction rvalid after reset", instr_rsp.rvalid, 1'b0);
        check("data rvalid after reset", data_rsp.rvalid, 1'b0);
        test_ram_data();
        test_instr_port();
        test_decoder();
        test_exit_status();
        test_timer();
        test_sw_irq();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(TEST_CYCLES * CLK_PERIOD + MARGIN_NS);
        $display("watchdog expired before the tests finished, %0d errors so far", errors);
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: src/data_decoder.sv
// data port address decoder
// steers requests to the RAM or to the memory mapped peripherals
// generates grant and response valid and selects the read data source

`include "mm_defines.svh"

module data_decoder
    import mem_bus_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,

    input  data_req_t data_req_i,
    output data_rsp_t data_rsp_o,

    input  word_t     ram_rdata_i,
    input  word_t     timer_rdata_i,

    output logic      ram_en_o,
    output logic      ram_we_o,
    output logic      periph_we_o
);

    logic  ram_hit;
    logic  timer_hit;
    logic  periph_hit;

    logic  rvalid_q;
    logic  sel_ram_q;
    logic  sel_timer_q;
    word_t rdata;

    // the RAM occupies the bottom of the address space
    assign ram_hit   = (data_req_i.addr[31:`MM_RAM_ADDR_WIDTH] == '0);
    assign timer_hit = (data_req_i.addr == `MM_TIMER_CNT_ADDR);

    assign periph_hit = timer_hit
                     || (data_req_i.addr == `MM_SW_IRQ_ADDR)
                     || (data_req_i.addr == `MM_TEST_STATUS_ADDR)
                     || (data_req_i.addr == `MM_EXIT_ADDR);

    assign ram_en_o    = data_req_i.req && ram_hit;
    assign ram_we_o    = data_req_i.req && ram_hit && data_req_i.we;
    // writes to unmapped addresses go nowhere
    assign periph_we_o = data_req_i.req && periph_hit && data_req_i.we;

    // remember where the read data of this request will come from
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rvalid_q    <= 1'b0;
            sel_ram_q   <= 1'b0;
            sel_timer_q <= 1'b0;
        end else begin
            rvalid_q    <= data_req_i.req;
            sel_ram_q   <= data_req_i.req && ram_hit && !data_req_i.we;
            sel_timer_q <= data_req_i.req && timer_hit && !data_req_i.we;
        end
    end

    // writes and unmapped reads answer with zero
    always_comb begin
        if (sel_ram_q) begin
            rdata = ram_rdata_i;
        end else if (sel_timer_q) begin
            rdata = timer_rdata_i;
        end else begin
            rdata = '0;
        end
    end

    // no back-pressure, every request is granted at once
    assign data_rsp_o.gnt    = data_req_i.req;
    assign data_rsp_o.rvalid = rvalid_q;
    assign data_rsp_o.rdata  = rdata;

endmodule

// File: src/dp_ram.sv
// word-wide RAM shared by instruction fetch and data accesses
// registered read port for instructions
// registered read/write port with byte enables for data

`include "mm_defines.svh"

module dp_ram
    import mem_bus_pkg::*;
(
    input  logic  clk_i,
    input  logic  arst_n_i,

    input  addr_t instr_addr_i,
    input  logic  instr_en_i,
    output word_t instr_rdata_o,

    input  addr_t data_addr_i,
    input  logic  data_en_i,
    input  logic  data_we_i,
    input  be_t   data_be_i,
    input  word_t data_wdata_i,
    output word_t data_rdata_o
);

    localparam int WORDS = 2 ** (`MM_RAM_ADDR_WIDTH - 2);

    word_t mem [WORDS];

    logic [`MM_RAM_ADDR_WIDTH-3:0] instr_idx;
    logic [`MM_RAM_ADDR_WIDTH-3:0] data_idx;

    // byte offset bits are dropped, the RAM is word addressed
    assign instr_idx = instr_addr_i[`MM_RAM_ADDR_WIDTH-1:2];
    assign data_idx  = data_addr_i[`MM_RAM_ADDR_WIDTH-1:2];

    always_ff @(posedge clk_i) begin
        if (data_en_i && data_we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (data_be_i[b]) begin
                    mem[data_idx][8*b +: 8] <= data_wdata_i[8*b +: 8];
                end
            end
        end
    end

    // nonblocking reads see the contents from before a write in the same cycle
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            instr_rdata_o <= '0;
            data_rdata_o  <= '0;
        end else begin
            if (instr_en_i) begin
                instr_rdata_o <= mem[instr_idx];
            end
            if (data_en_i && !data_we_i) begin
                data_rdata_o <= mem[data_idx];
            end
        end
    end

endmodule

// File: src/exit_ctrl.sv
// exit/status pseudo peripheral
// sticky passed and failed flags set by magic status writes
// exit value register with a sticky valid flag

`include "mm_defines.svh"

module exit_ctrl
    import mem_bus_pkg::*;
(
    input  logic  clk_i,
    input  logic  arst_n_i,

    input  logic  we_i,
    input  addr_t addr_i,
    input  word_t wdata_i,

    output logic  tests_passed_o,
    output logic  tests_failed_o,
    output logic  exit_valid_o,
    output word_t exit_value_o
);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tests_passed_o <= 1'b0;
            tests_failed_o <= 1'b0;
            exit_valid_o   <= 1'b0;
            exit_value_o   <= '0;
        end else if (we_i) begin
            // a status value other than the two magics leaves the flags alone
            if (addr_i == `MM_TEST_STATUS_ADDR) begin
                if (wdata_i == `MM_PASS_MAGIC) begin
                    tests_passed_o <= 1'b1;
                end else if (wdata_i == `MM_FAIL_MAGIC) begin
                    tests_failed_o <= 1'b1;
                end
            end
            if (addr_i == `MM_EXIT_ADDR) begin
                exit_value_o <= wdata_i;
                exit_valid_o <= 1'b1;
            end
        end
    end

endmodule

// File: src/irq_pkg.sv
// interrupt types shared by the timer block and the core side
// interrupt id vector, interrupt line struct and timer FSM states
// ids of the software and timer interrupts

package irq_pkg;

    typedef logic [4:0] irq_id_t;

    typedef struct packed {
        logic software;
        logic timer;
    } irq_lines_t;

    typedef enum logic [1:0] {
        TMR_IDLE,
        TMR_COUNT,
        TMR_FIRED
    } timer_state_t;

    // ids follow the machine interrupt numbering of the core
    localparam irq_id_t IRQ_ID_SOFTWARE = 5'd3;
    localparam irq_id_t IRQ_ID_TIMER    = 5'd7;

endpackage

// File: src/mem_bus_pkg.sv
// bus types of the core side memory ports
// word, byte address and byte enable vectors
// request and response structs of the instruction and data ports

package mem_bus_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  be_t;

    // instruction fetch request from the core
    typedef struct packed {
        logic  req;
        addr_t addr;
    } instr_req_t;

    typedef struct packed {
        logic  gnt;
        logic  rvalid;
        word_t rdata;
    } instr_rsp_t;

    // load/store request, be selects the bytes written
    typedef struct packed {
        logic  req;
        addr_t addr;
        logic  we;
        be_t   be;
        word_t wdata;
    } data_req_t;

    typedef struct packed {
        logic  gnt;
        logic  rvalid;
        word_t rdata;
    } data_rsp_t;

endpackage

// File: src/mm_defines.svh
// address map and RAM size for the memory subsystem
// RAM window, status/exit registers, timer and software interrupt registers
// magic values written by a test program to report pass or fail

`ifndef MM_DEFINES_SVH
`define MM_DEFINES_SVH

// byte address width of the RAM window that starts at address zero
`define MM_RAM_ADDR_WIDTH 16

// exit/status pseudo peripheral
`define MM_TEST_STATUS_ADDR 32'h2000_0000
`define MM_EXIT_ADDR        32'h2000_0004

// timer and software interrupt source
`define MM_TIMER_CNT_ADDR   32'h1500_0000
`define MM_SW_IRQ_ADDR      32'h1500_0008

// values accepted by the status register
`define MM_PASS_MAGIC       32'd123456789
`define MM_FAIL_MAGIC       32'd1

`endif

// File: src/mm_ram_top.sv
// memory subsystem seen by the core
// shared RAM with instruction and data ports, data address decoder
// exit/status pseudo peripheral and the timer/software interrupt source

`include "mm_defines.svh"

module mm_ram_top
    import mem_bus_pkg::*;
    import irq_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,

    input  instr_req_t instr_req_i,
    output instr_rsp_t instr_rsp_o,

    input  data_req_t  data_req_i,
    output data_rsp_t  data_rsp_o,

    input  irq_id_t    irq_id_i,
    input  logic       irq_ack_i,
    output irq_lines_t irq_o,

    output logic       tests_passed_o,
    output logic       tests_failed_o,
    output logic       exit_valid_o,
    output word_t      exit_value_o
);

    addr_t instr_addr;
    word_t instr_rdata;
    logic  instr_rvalid_q;

    word_t ram_rdata;
    word_t timer_cnt;
    logic  ram_en;
    logic  ram_we;
    logic  periph_we;

    // instruction fetches always land in the RAM, upper address bits ignored
    assign instr_addr = addr_t'(instr_req_i.addr[`MM_RAM_ADDR_WIDTH-1:0]);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            instr_rvalid_q <= 1'b0;
        end else begin
            instr_rvalid_q <= instr_req_i.req;
        end
    end

    assign instr_rsp_o.gnt    = instr_req_i.req;
    assign instr_rsp_o.rvalid = instr_rvalid_q;
    assign instr_rsp_o.rdata  = instr_rdata;

    dp_ram ram_i (
        .clk_i         ( clk_i            ),
        .arst_n_i      ( arst_n_i         ),
        .instr_addr_i  ( instr_addr       ),
        .instr_en_i    ( instr_req_i.req  ),
        .instr_rdata_o ( instr_rdata      ),
        .data_addr_i   ( data_req_i.addr  ),
        .data_en_i     ( ram_en           ),
        .data_we_i     ( ram_we           ),
        .data_be_i     ( data_req_i.be    ),
        .data_wdata_i  ( data_req_i.wdata ),
        .data_rdata_o  ( ram_rdata        )
    );

    data_decoder decoder_i (
        .clk_i         ( clk_i            ),
        .arst_n_i      ( arst_n_i         ),
        .data_req_i    ( data_req_i       ),
        .data_rsp_o    ( data_rsp_o       ),
        .ram_rdata_i   ( ram_rdata        ),
        .timer_rdata_i ( timer_cnt        ),
        .ram_en_o      ( ram_en           ),
        .ram_we_o      ( ram_we           ),
        .periph_we_o   ( periph_we        )
    );

    exit_ctrl exit_i (
        .clk_i          ( clk_i            ),
        .arst_n_i       ( arst_n_i         ),
        .we_i           ( periph_we        ),
        .addr_i         ( data_req_i.addr  ),
        .wdata_i        ( data_req_i.wdata ),
        .tests_passed_o ( tests_passed_o   ),
        .tests_failed_o ( tests_failed_o   ),
        .exit_valid_o   ( exit_valid_o     ),
        .exit_value_o   ( exit_value_o     )
    );

    timer_irq timer_i (
        .clk_i     ( clk_i            ),
        .arst_n_i  ( arst_n_i         ),
        .we_i      ( periph_we        ),
        .addr_i    ( data_req_i.addr  ),
        .wdata_i   ( data_req_i.wdata ),
        .irq_id_i  ( irq_id_i         ),
        .irq_ack_i ( irq_ack_i        ),
        .cnt_o     ( timer_cnt        ),
        .irq_o     ( irq_o            )
    );

endmodule

// File: src/timer_irq.sv
// timer and software interrupt source
// countdown timer FSM that raises the timer line when the count runs out
// software interrupt register, both lines cleared by the core acknowledge

`include "mm_defines.svh"

module timer_irq
    import mem_bus_pkg::*;
    import irq_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,

    input  logic       we_i,
    input  addr_t      addr_i,
    input  word_t      wdata_i,

    input  irq_id_t    irq_id_i,
    input  logic       irq_ack_i,

    output word_t      cnt_o,
    output irq_lines_t irq_o
);

    timer_state_t state_q;
    timer_state_t state_d;
    word_t        cnt_q;
    word_t        cnt_d;
    logic         load;
    logic         timer_ack;
    logic         sw_ack;
    logic         sw_irq_q;

    assign load      = we_i && (addr_i == `MM_TIMER_CNT_ADDR);
    assign timer_ack = irq_ack_i && (irq_id_i == IRQ_ID_TIMER);
    assign sw_ack    = irq_ack_i && (irq_id_i == IRQ_ID_SOFTWARE);

    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        case (state_q)
            TMR_IDLE, TMR_COUNT: begin
                if (load) begin
                    // loading zero leaves the timer disarmed
                    cnt_d   = wdata_i;
                    state_d = (wdata_i == '0) ? TMR_IDLE : TMR_COUNT;
                end else if (state_q == TMR_COUNT) begin
                    cnt_d = cnt_q - 32'd1;
                    if (cnt_q == 32'd1) begin
                        state_d = TMR_FIRED;
                    end
                end
            end
            TMR_FIRED: begin
                // the line stays up until the core takes the interrupt
                if (timer_ack) begin
                    state_d = TMR_IDLE;
                end
            end
            default: begin
                state_d = TMR_IDLE;
                cnt_d   = '0;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q  <= TMR_IDLE;
            cnt_q    <= '0;
            sw_irq_q <= 1'b0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
            // a new software request wins over an acknowledge in the same cycle
            if (we_i && (addr_i == `MM_SW_IRQ_ADDR) && wdata_i[0]) begin
                sw_irq_q <= 1'b1;
            end else if (sw_ack) begin
                sw_irq_q <= 1'b0;
            end
        end
    end

    assign cnt_o          = cnt_q;
    assign irq_o.timer    = (state_q == TMR_FIRED);
    assign irq_o.software = sw_irq_q;

endmodule
